// ==== include/ib_params.svh ====
`ifndef IB_PARAMS_SVH
`define IB_PARAMS_SVH

// lane count, power of two
`define IB_CHANNEL 4

// entries per lane, power of two
`define IB_DEPTH 8

`define IB_XLEN 32   // pc and instruction width

// apb address bits, covers 0x0 to 0xf
`define IB_APB_AW 4

`endif

// ==== design/ib_entry_pkg.sv ====
`include "ib_params.svh"

package ib_entry_pkg;

	// one fetched instruction as it travels to decode
	typedef struct packed {
		logic [`IB_XLEN-1:0] pc;
		logic [`IB_XLEN-1:0] instr;
	} fetch_entry_t;

	// physical lane number, also used for request slot offsets
	typedef logic [$clog2(`IB_CHANNEL)-1:0] lane_idx_t;

	// entries moved per cycle, 0 up to a full row
	typedef logic [$clog2(`IB_CHANNEL + 1)-1:0] lane_cnt_t;

endpackage

// ==== design/ib_csr_pkg.sv ====
`include "ib_params.svh"

package ib_csr_pkg;

	// register map, byte addresses
	typedef enum logic [`IB_APB_AW-1:0] {
		CTRL     = 'h0,
		STATUS   = 'h4,
		PUSH_CNT = 'h8,
		POP_CNT  = 'hC
	} csr_addr_e;

	typedef struct packed {
		logic [30:0] rsvd;
		logic        flush;  // write 1 to drop all entries
	} ib_ctrl_t;

	typedef struct packed {
		logic full;
		logic empty;
	} ib_status_t;

endpackage

// ==== design/ib_lane_fifo.sv ====
`timescale 1ns/1ps

`include "ib_params.svh"

module ib_lane_fifo import ib_entry_pkg::*; #(
	parameter int unsigned DEPTH = `IB_DEPTH  // power of two, at least 2
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         flush_i,
	input  logic         push_i,
	input  logic         pop_i,
	input  fetch_entry_t data_i,
	output fetch_entry_t data_o,
	output logic         full_o,
	output logic         empty_o
);

	localparam int unsigned PW = $clog2(DEPTH);
	localparam int unsigned CW = $clog2(DEPTH + 1);

	fetch_entry_t  mem [DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [CW-1:0] count;  // occupancy
	logic          push_ok;
	logic          pop_ok;

	assign full_o  = (count == CW'(DEPTH));
	assign empty_o = (count == '0);
	assign push_ok = push_i & ~full_o;
	assign pop_ok  = pop_i & ~empty_o;

	assign data_o = mem[rd_ptr];  // head entry, no read latency

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + PW'(1);  // wraps at DEPTH
			if (pop_ok)
				rd_ptr <= rd_ptr + PW'(1);
			case ({push_ok, pop_ok})
				2'b10:   count <= count + CW'(1);
				2'b01:   count <= count - CW'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_ptr] <= data_i;
	end

	// the queue above must never steer a push into a full lane
	a_push_full: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o)
		else $error("ib_lane_fifo: push into full lane");

	a_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
		else $error("ib_lane_fifo: pop from empty lane");

endmodule

// ==== design/multi_queue.sv ====
`timescale 1ns/1ps

`include "ib_params.svh"

module multi_queue import ib_entry_pkg::*; #(
	parameter int unsigned CHANNEL = `IB_CHANNEL,  // power of two
	parameter int unsigned DEPTH   = `IB_DEPTH     // per lane, power of two
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush_i,
	input  logic                       stall_push_i,
	input  logic                       stall_pop_i,
	input  fetch_entry_t [CHANNEL-1:0] data_push_i,
	input  lane_cnt_t                  push_num_i,
	input  lane_idx_t                  push_offset_i,
	input  lane_cnt_t                  pop_num_i,
	output logic                       full_o,   // some lane is full
	output logic                       empty_o,  // every lane is empty
	output fetch_entry_t [CHANNEL-1:0] data_pop_o,
	output logic [CHANNEL-1:0]         pop_valid_o
);

	logic [CHANNEL-1:0]         lane_push;
	logic [CHANNEL-1:0]         lane_pop;
	logic [CHANNEL-1:0]         lane_full;
	logic [CHANNEL-1:0]         lane_empty;
	fetch_entry_t [CHANNEL-1:0] lane_din;
	fetch_entry_t [CHANNEL-1:0] lane_dout;
	lane_idx_t                  rd_ptr;  // lane holding the oldest entry
	lane_idx_t                  wr_ptr;  // lane taking the next entry
	logic                       push_en;
	logic                       pop_en;

	assign push_en = ~stall_push_i & ~flush_i;
	assign pop_en  = ~stall_pop_i & ~flush_i;

	assign full_o  = |lane_full;
	assign empty_o = &lane_empty;

	for (genvar i = 0; i < CHANNEL; i++) begin : gen_lane
		lane_idx_t head_lane;  // lane of the i-th oldest entry
		lane_idx_t wr_slot;    // request slot that lands in lane i
		lane_idx_t rd_slot;    // pop slot served by lane i
		lane_idx_t src_slot;   // position in data_push_i

		assign head_lane = rd_ptr + lane_idx_t'(i);
		assign wr_slot   = lane_idx_t'(i) - wr_ptr;
		assign rd_slot   = lane_idx_t'(i) - rd_ptr;
		assign src_slot  = push_offset_i + wr_slot;

		// gather back into program order
		assign data_pop_o[i]  = lane_dout[head_lane];
		assign pop_valid_o[i] = ~lane_empty[head_lane];

		// scatter from the request row
		assign lane_din[i]  = data_push_i[src_slot];
		assign lane_push[i] = push_en & (lane_cnt_t'(wr_slot) < push_num_i);
		assign lane_pop[i]  = pop_en & (lane_cnt_t'(rd_slot) < pop_num_i);

		ib_lane_fifo #(
			.DEPTH   (DEPTH)
		) u_lane (
			.clk     (clk),
			.rst     (rst),
			.flush_i (flush_i),
			.push_i  (lane_push[i]),
			.pop_i   (lane_pop[i]),
			.data_i  (lane_din[i]),
			.data_o  (lane_dout[i]),
			.full_o  (lane_full[i]),
			.empty_o (lane_empty[i])
		);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			if (!stall_pop_i)
				rd_ptr <= rd_ptr + lane_idx_t'(pop_num_i);  // full row wraps to same lane
			if (!stall_push_i)
				wr_ptr <= wr_ptr + lane_idx_t'(push_num_i);
		end
	end

	// fetch side must hold off while full
	a_push_when_full: assert property (@(posedge clk) disable iff (rst)
		(push_en && push_num_i != '0) |-> !full_o)
		else $error("multi_queue: push accepted while full");

	// decode side may only take what is shown as valid
	a_pop_over_valid: assert property (@(posedge clk) disable iff (rst)
		pop_en |-> (int'(pop_num_i) <= $countones(pop_valid_o)))
		else $error("multi_queue: pop_num exceeds valid lanes");

endmodule

// ==== design/ib_apb_regs.sv ====
`timescale 1ns/1ps

`include "ib_params.svh"

module ib_apb_regs import ib_entry_pkg::*, ib_csr_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`IB_APB_AW-1:0] paddr_i,
	input  logic [31:0]           pwdata_i,
	input  logic                  flush_i,  // fetch redirect
	input  logic                  full_i,
	input  logic                  empty_i,
	input  lane_cnt_t             push_num_i,
	input  logic                  stall_push_i,
	input  lane_cnt_t             pop_num_i,
	input  logic                  stall_pop_i,
	output logic [31:0]           prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output logic                  flush_o
);

	logic        access;   // apb access phase
	logic        addr_ok;
	logic [31:0] rdata;
	logic [31:0] push_cnt;
	logic [31:0] pop_cnt;
	logic        sw_flush;
	ib_ctrl_t    ctrl_wr;
	ib_status_t  status;

	assign access  = psel_i & penable_i;
	assign ctrl_wr = ib_ctrl_t'(pwdata_i);
	assign status  = {full_i, empty_i};

	// high for the single access cycle, so lanes clear at the closing edge
	assign sw_flush = access & pwrite_i & (paddr_i == CTRL) & ctrl_wr.flush;
	assign flush_o  = flush_i | sw_flush;

	always_comb begin
		rdata   = '0;
		addr_ok = 1'b1;
		case (paddr_i)
			CTRL:     rdata = '0;  // flush bit never reads back
			STATUS:   rdata = 32'(status);
			PUSH_CNT: rdata = push_cnt;
			POP_CNT:  rdata = pop_cnt;
			default:  addr_ok = 1'b0;
		endcase
	end

	assign prdata_o  = access ? rdata : '0;
	assign pready_o  = 1'b1;  // no wait states
	assign pslverr_o = access & ~addr_ok;

	// running totals, kept across flushes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			push_cnt <= '0;
			pop_cnt  <= '0;
		end else begin
			if (!stall_push_i && !flush_o)
				push_cnt <= push_cnt + 32'(push_num_i);
			if (!stall_pop_i && !flush_o)
				pop_cnt <= pop_cnt + 32'(pop_num_i);
		end
	end

	a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable_i |-> psel_i)
		else $error("ib_apb_regs: penable without psel");

endmodule

// ==== design/instr_buffer_top.sv ====
`timescale 1ns/1ps

`include "ib_params.svh"

module instr_buffer_top import ib_entry_pkg::*; (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush_i,
	// fetch side
	input  fetch_entry_t [`IB_CHANNEL-1:0] data_push_i,
	input  lane_cnt_t                      push_num_i,
	input  lane_idx_t                      push_offset_i,
	input  logic                           stall_push_i,
	output logic                           full_o,
	// decode side
	input  lane_cnt_t                      pop_num_i,
	input  logic                           stall_pop_i,
	output fetch_entry_t [`IB_CHANNEL-1:0] data_pop_o,
	output logic [`IB_CHANNEL-1:0]         pop_valid_o,
	output logic                           empty_o,
	// apb slave
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [`IB_APB_AW-1:0]          paddr_i,
	input  logic [31:0]                    pwdata_i,
	output logic [31:0]                    prdata_o,
	output logic                           pready_o,
	output logic                           pslverr_o
);

	logic flush;  // redirect or software request

	multi_queue #(
		.CHANNEL       (`IB_CHANNEL),
		.DEPTH         (`IB_DEPTH)
	) u_queue (
		.clk           (clk),
		.rst           (rst),
		.flush_i       (flush),
		.stall_push_i  (stall_push_i),
		.stall_pop_i   (stall_pop_i),
		.data_push_i   (data_push_i),
		.push_num_i    (push_num_i),
		.push_offset_i (push_offset_i),
		.pop_num_i     (pop_num_i),
		.full_o        (full_o),
		.empty_o       (empty_o),
		.data_pop_o    (data_pop_o),
		.pop_valid_o   (pop_valid_o)
	);

	ib_apb_regs u_regs (
		.clk           (clk),
		.rst           (rst),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.flush_i       (flush_i),
		.full_i        (full_o),
		.empty_i       (empty_o),
		.push_num_i    (push_num_i),
		.stall_push_i  (stall_push_i),
		.pop_num_i     (pop_num_i),
		.stall_pop_i   (stall_pop_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.flush_o       (flush)
	);

endmodule

// ==== verification/instr_buffer_tb.sv ====
`timescale 1ns/1ps

`include "ib_params.svh"

module instr_buffer_tb import ib_entry_pkg::*, ib_csr_pkg::*; ();

	localparam int CH        = `IB_CHANNEL;
	localparam int DEPTH     = `IB_DEPTH;
	localparam int FULL_MARK = CH * (DEPTH - 1);  // above this some lane is full
	localparam int TIMEOUT   = 1000;

	logic                  clk;
	logic                  rst;
	logic                  flush;
	logic                  stall_push;
	logic                  stall_pop;
	fetch_entry_t [CH-1:0] data_push;
	fetch_entry_t [CH-1:0] data_pop;
	lane_cnt_t             push_num;
	lane_cnt_t             pop_num;
	lane_idx_t             push_offset;
	logic [CH-1:0]         pop_valid;
	logic                  full;
	logic                  empty;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`IB_APB_AW-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	// reference model
	fetch_entry_t          model_q [$];
	int                    model_cnt;
	fetch_entry_t [CH-1:0] exp_head;
	logic [CH-1:0]         exp_valid;
	logic [31:0]           exp_push_cnt;
	logic [31:0]           exp_pop_cnt;
	logic                  exp_full;
	logic                  exp_empty;
	int                    cycles = 0;
	logic                  flush_any;
	logic                  apb_rd;

	assign flush_any = flush | (psel & penable & pwrite & (paddr == CTRL) & pwdata[0]);
	assign apb_rd    = psel & penable & ~pwrite;

	instr_buffer_top uut (
		.clk           (clk),
		.rst           (rst),
		.flush_i       (flush),
		.data_push_i   (data_push),
		.push_num_i    (push_num),
		.push_offset_i (push_offset),
		.stall_push_i  (stall_push),
		.full_o        (full),
		.pop_num_i     (pop_num),
		.stall_pop_i   (stall_pop),
		.data_pop_o    (data_pop),
		.pop_valid_o   (pop_valid),
		.empty_o       (empty),
		.psel_i        (psel),
		.penable_i     (penable),
		.pwrite_i      (pwrite),
		.paddr_i       (paddr),
		.pwdata_i      (pwdata),
		.prdata_o      (prdata),
		.pready_o      (pready),
		.pslverr_o     (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic report_mismatch(string sig, logic [63:0] got, logic [63:0] exp);
		$display("MISMATCH %s got 0x%h expected 0x%h", sig, got, exp);
		$display("TEST FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic report_error(string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "check failed");
	endtask

	function automatic logic is_unmapped(logic [`IB_APB_AW-1:0] addr);
		return !(addr inside {4'h0, 4'h4, 4'h8, 4'hC});
	endfunction

	a_valid: assert property (@(posedge clk) disable iff (rst) pop_valid == exp_valid)
		else report_mismatch("pop_valid_o", 64'($sampled(pop_valid)), 64'($sampled(exp_valid)));
	a_empty: assert property (@(posedge clk) disable iff (rst) empty == exp_empty)
		else report_mismatch("empty_o", 64'($sampled(empty)), 64'($sampled(exp_empty)));
	a_full: assert property (@(posedge clk) disable iff (rst) full == exp_full)
		else report_mismatch("full_o", 64'($sampled(full)), 64'($sampled(exp_full)));

	for (genvar i = 0; i < CH; i++) begin : gen_order
		a_order: assert property (@(posedge clk) disable iff (rst)
			exp_valid[i] |-> data_pop[i] == exp_head[i])
			else report_mismatch($sformatf("data_pop_o[%0d]", i),
				$sampled(data_pop[i]), $sampled(exp_head[i]));
	end

	// decode and fetch both stalled, nothing may move
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(stall_pop && stall_push && !flush_any) |=> $stable(data_pop) && $stable(pop_valid))
		else report_error("pop outputs changed while decode was stalled");
	a_flush_clear: assert property (@(posedge clk) disable iff (rst)
		flush_any |=> empty && pop_valid == '0)
		else report_error("queue not empty after a flush");

	a_rd_status: assert property (@(posedge clk) disable iff (rst)
		(apb_rd && paddr == STATUS) |-> prdata == {30'b0, exp_full, exp_empty})
		else report_mismatch("prdata_o", 64'($sampled(prdata)),
			64'({$sampled(exp_full), $sampled(exp_empty)}));
	a_rd_push: assert property (@(posedge clk) disable iff (rst)
		(apb_rd && paddr == PUSH_CNT) |-> prdata == exp_push_cnt)
		else report_mismatch("prdata_o", 64'($sampled(prdata)), 64'($sampled(exp_push_cnt)));
	a_rd_pop: assert property (@(posedge clk) disable iff (rst)
		(apb_rd && paddr == POP_CNT) |-> prdata == exp_pop_cnt)
		else report_mismatch("prdata_o", 64'($sampled(prdata)), 64'($sampled(exp_pop_cnt)));
	a_rd_ctrl: assert property (@(posedge clk) disable iff (rst)
		(apb_rd && paddr == CTRL) |-> prdata == '0)
		else report_mismatch("prdata_o", 64'($sampled(prdata)), 64'h0);
	a_slverr: assert property (@(posedge clk) disable iff (rst)
		(psel && penable) |-> pslverr == is_unmapped(paddr))
		else report_mismatch("pslverr_o", 64'($sampled(pslverr)),
			64'(is_unmapped($sampled(paddr))));
	a_pready: assert property (@(posedge clk) pready)
		else report_error("pready_o dropped low");

	// applies the inputs seen at this edge, same rules as the buffer
	task automatic update_model();
		if (flush_any) begin
			model_q.delete();
		end else begin
			if (!stall_pop) begin
				for (int k = 0; k < int'(pop_num); k++)
					void'(model_q.pop_front());
				exp_pop_cnt += 32'(pop_num);
			end
			if (!stall_push) begin
				for (int k = 0; k < int'(push_num); k++)
					model_q.push_back(data_push[lane_idx_t'(int'(push_offset) + k)]);
				exp_push_cnt += 32'(push_num);
			end
		end
		model_cnt = model_q.size();
		for (int k = 0; k < CH; k++) begin
			exp_valid[k] = (k < model_cnt);
			exp_head[k]  = (k < model_cnt) ? model_q[k] : '0;
		end
		exp_full  = (model_cnt > FULL_MARK);
		exp_empty = (model_cnt == 0);
	endtask

	task automatic step();
		@(posedge clk);
		if (!rst)
			update_model();
	endtask

	// one cycle of fetch and decode traffic, pop_pct sets how often decode takes
	task automatic random_cycle(int pop_pct);
		int n;
		int p;
		step();
		n = $urandom_range(CH, 0);
		if (model_cnt > FULL_MARK)
			n = 0;  // full, fetch holds off
		else if (n > CH * DEPTH - model_cnt)
			n = CH * DEPTH - model_cnt;
		p = $urandom_range(CH, 0);
		if (p > model_cnt)
			p = model_cnt;
		push_num    <= lane_cnt_t'(n);
		pop_num     <= lane_cnt_t'(p);
		push_offset <= lane_idx_t'($urandom());
		stall_push  <= ($urandom_range(3, 0) == 0);
		stall_pop   <= ($urandom_range(99, 0) >= pop_pct);
		flush       <= ($urandom_range(79, 0) == 0);  // rare redirect
		for (int k = 0; k < CH; k++) begin
			data_push[k].pc    <= $urandom();
			data_push[k].instr <= $urandom();
		end
	endtask

	task automatic apb_access(logic wr, logic [`IB_APB_AW-1:0] addr, logic [31:0] data);
		step();
		push_num <= '0;
		pop_num  <= '0;
		flush    <= 1'b0;
		psel     <= 1'b1;  // setup phase
		penable  <= 1'b0;
		pwrite   <= wr;
		paddr    <= addr;
		pwdata   <= data;
		step();
		penable  <= 1'b1;
		step();
		psel     <= 1'b0;
		penable  <= 1'b0;
	endtask

	initial begin
		void'($urandom(64193));
		rst          = 1'b1;
		flush        = 1'b0;
		stall_push   = 1'b0;
		stall_pop    = 1'b0;
		data_push    = '0;
		push_num     = '0;
		pop_num      = '0;
		push_offset  = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		model_cnt    = 0;
		exp_head     = '0;
		exp_valid    = '0;
		exp_push_cnt = '0;
		exp_pop_cnt  = '0;
		exp_full     = 1'b0;
		exp_empty    = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// whole map after reset, unmapped holes included
		for (int a = 0; a < 16; a++)
			apb_access(1'b0, `IB_APB_AW'(a), 32'h0);

		repeat (200) random_cycle(15);  // mostly fill
		repeat (200) random_cycle(85);  // mostly drain
		repeat (100) random_cycle(50);
		apb_access(1'b0, STATUS, 32'h0);
		apb_access(1'b0, PUSH_CNT, 32'h0);
		apb_access(1'b0, POP_CNT, 32'h0);

		// software flush with entries held
		repeat (20) random_cycle(0);
		apb_access(1'b0, STATUS, 32'h0);  // usually full by now
		apb_access(1'b1, CTRL, 32'h0);  // entries must stay
		apb_access(1'b1, CTRL, 32'h1);
		apb_access(1'b0, CTRL, 32'h0);
		apb_access(1'b0, STATUS, 32'h0);
		step();
		step();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== instr_buffer_top.f ====
+incdir+include
design/ib_entry_pkg.sv
design/ib_csr_pkg.sv
design/ib_lane_fifo.sv
design/multi_queue.sv
design/ib_apb_regs.sv
design/instr_buffer_top.sv
verification/instr_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= instr_buffer_tb
RTL_TOP   ?= instr_buffer_top
FILELIST  ?= instr_buffer_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
